// File: mem_bus_pkg.sv
// Memory bus types: command enum, transaction tag, address and data words, memory depth
package mem_bus_pkg;

    // Command on the shared memory port
    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } MEM_COMMAND;

    typedef logic [3:0]  MEM_TAG; // Zero is no transaction
    typedef logic [31:0] ADDR;    // Byte address, word aligned
    typedef logic [31:0] DATA;

    // Refused request or idle return slot
    localparam MEM_TAG NO_TAG = 4'd0;

    // Words in the memory model, also bounds legal addresses
    localparam int MEM_WORDS = 1024;

endpackage

// File: cpu_types_pkg.sv
// CPU types: instruction fields, opcode and ALU enums, stage packets and their empty values
package cpu_types_pkg;
    import mem_bus_pkg::*;

    typedef logic [31:0] INST;
    typedef logic [4:0]  REG_IDX;

    // R-type view of an instruction word
    typedef struct packed {
        logic [6:0] funct7;
        REG_IDX     rs2;
        REG_IDX     rs1;
        logic [2:0] funct3;
        REG_IDX     rd;
        logic [6:0] opcode;
    } INST_FIELDS;

    typedef enum logic [6:0] {
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_SYSTEM = 7'b1110011
    } OPCODE;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_PASS // Operand B straight through
    } ALU_FUNC;

    typedef enum logic {
        OPB_IS_RS2,
        OPB_IS_IMM
    } OPB_SELECT;

    localparam INST        NOP      = 32'h0000_0013; // ADDI x0,x0,0
    localparam INST        EBREAK   = 32'h0010_0073;
    localparam REG_IDX     ZERO_REG = 5'd0;
    localparam logic [2:0] F3_ADD   = 3'b000;        // ADDI, ADD, SUB, BEQ
    localparam logic [2:0] F3_WORD  = 3'b010;        // LW, SW
    localparam logic [6:0] F7_ADD   = 7'b0000000;
    localparam logic [6:0] F7_SUB   = 7'b0100000;

    typedef struct packed {
        INST  inst;
        ADDR  pc;
        ADDR  npc;
        logic valid;
    } IF_ID_PACKET; // 97 bits

    typedef struct packed {
        INST       inst;
        ADDR       pc;
        ADDR       npc;
        DATA       rs1_value;
        DATA       rs2_value;
        DATA       imm;
        OPB_SELECT opb_select;
        REG_IDX    dest_reg;    // x0 when nothing is written
        ALU_FUNC   alu_func;
        logic      rd_mem;
        logic      wr_mem;
        logic      cond_branch;
        logic      halt;
        logic      valid;
    } ID_EX_PACKET;

    typedef struct packed {
        DATA    alu_result;  // Address for memory ops, target for taken BEQ
        ADDR    npc;
        DATA    rs2_value;   // Store data
        REG_IDX dest_reg;
        logic   rd_mem;
        logic   wr_mem;
        logic   take_branch;
        logic   halt;
        logic   valid;
    } EX_MEM_PACKET;

    typedef struct packed {
        DATA    result;
        ADDR    npc;
        REG_IDX dest_reg;
        logic   halt;
        logic   valid;
    } MEM_WB_PACKET;

    // Bubbles; NOP is nonzero so the front two need named fields
    localparam IF_ID_PACKET  IF_ID_EMPTY  = '{inst: NOP, default: '0};
    localparam ID_EX_PACKET  ID_EX_EMPTY  = '{
        inst: NOP, opb_select: OPB_IS_RS2, alu_func: ALU_ADD, default: '0
    };
    localparam EX_MEM_PACKET EX_MEM_EMPTY = '0;
    localparam MEM_WB_PACKET MEM_WB_EMPTY = '0;

endpackage

// File: dmem_if.sv
// Data memory interface between the memory stage and the memory controller
`timescale 1ns/1ps
interface dmem_if import mem_bus_pkg::*; ();

    MEM_COMMAND command;    // MEM_NONE when the stage is idle
    ADDR        addr;
    DATA        store_data;
    DATA        load_data;  // Valid with done on a load
    logic       done;       // Store accepted or load tag returned

    modport mem_stage (
        output command, addr, store_data,
        input  load_data, done
    );

    modport ctrl (
        input  command, addr, store_data,
        output load_data, done
    );

endinterface

// File: pipe_reg.sv
// Stage register with hold and flush, typed by the packet it carries
`timescale 1ns/1ps
module pipe_reg #(
    parameter type   PACKET = logic [31:0],
    parameter PACKET EMPTY  = '0
) (
    input  logic  clock,
    input  logic  reset,
    input  logic  hold,  // Keep current packet
    input  logic  flush, // Load a bubble
    input  PACKET d,
    output PACKET q
);

    // Flush beats hold, bubble wins over a stalled packet
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            q <= EMPTY;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

// File: stage_if.sv
// Fetch stage: PC, fetch request and tag wait, branch redirect
`timescale 1ns/1ps
module stage_if import mem_bus_pkg::*, cpu_types_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        if_valid,      // Token, start or writeback
    input  logic        halt_seen,
    input  logic        take_branch,
    input  ADDR         branch_target,
    input  MEM_TAG      fetch_tag,     // Nonzero only when fetch granted
    input  MEM_TAG      mem_data_tag,
    input  DATA         mem_data,
    output MEM_COMMAND  fetch_command,
    output ADDR         fetch_addr,
    output IF_ID_PACKET if_packet
);

    ADDR    pc;
    logic   pending;   // Token latched, request not yet accepted
    logic   waiting;   // Accepted, instruction not back yet
    MEM_TAG wait_tag;
    logic   data_back;

    assign data_back = waiting && (mem_data_tag == wait_tag);

    always_ff @(posedge clock) begin
        if (reset) begin
            pc       <= '0;
            pending  <= 1'b0;
            waiting  <= 1'b0;
            wait_tag <= NO_TAG;
        end else begin
            if (if_valid && !halt_seen) begin
                pending <= 1'b1;           // No more fetches once halted
            end
            if (pending && fetch_tag != NO_TAG) begin
                pending  <= 1'b0;
                waiting  <= 1'b1;
                wait_tag <= fetch_tag;     // Match against returning data
            end
            if (data_back) begin
                waiting <= 1'b0;
                pc      <= pc + 32'd4;     // Fall-through
            end
            if (take_branch) begin
                pc <= branch_target;       // Lands before the token comes back
            end
        end
    end

    assign fetch_command = pending ? MEM_LOAD : MEM_NONE; // Held until accepted
    assign fetch_addr    = pc;

    // Instruction valid only in the tag match cycle
    always_comb begin
        if_packet.inst  = data_back ? mem_data : NOP;
        if_packet.pc    = pc;
        if_packet.npc   = pc + 32'd4;
        if_packet.valid = data_back;
    end

endmodule

// File: stage_id.sv
// Decode stage: instruction decoder, immediates and the 32-entry register file
`timescale 1ns/1ps
module stage_id import mem_bus_pkg::*, cpu_types_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  IF_ID_PACKET if_id_reg,
    input  logic        wb_en,
    input  REG_IDX      wb_idx,
    input  DATA         wb_data,
    output ID_EX_PACKET id_packet
);

    DATA        regs [32];
    INST_FIELDS f;
    DATA        imm_i;
    DATA        imm_s;
    DATA        imm_b;

    assign f = if_id_reg.inst;

    // Sign-extended immediates
    assign imm_i = {{20{f.funct7[6]}}, f.funct7, f.rs2};
    assign imm_s = {{20{f.funct7[6]}}, f.funct7, f.rd};
    assign imm_b = {{19{f.funct7[6]}}, f.funct7[6], f.rd[0], f.funct7[5:0], f.rd[4:1], 1'b0};

    ////////////////////
    // Register file
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;             // Architectural state starts clean
            end
        end else if (wb_en && wb_idx != ZERO_REG) begin
            regs[wb_idx] <= wb_data;       // x0 never written
        end
    end

    ////////////////////
    // Decoder
    ////////////////////

    always_comb begin
        id_packet.inst        = if_id_reg.inst;
        id_packet.pc          = if_id_reg.pc;
        id_packet.npc         = if_id_reg.npc;
        id_packet.rs1_value   = (f.rs1 == ZERO_REG) ? '0 : regs[f.rs1];
        id_packet.rs2_value   = (f.rs2 == ZERO_REG) ? '0 : regs[f.rs2];
        id_packet.imm         = imm_i;
        id_packet.opb_select  = OPB_IS_IMM;
        id_packet.dest_reg    = ZERO_REG;  // Unknown ops commit with no write
        id_packet.alu_func    = ALU_PASS;
        id_packet.rd_mem      = 1'b0;
        id_packet.wr_mem      = 1'b0;
        id_packet.cond_branch = 1'b0;
        id_packet.halt        = 1'b0;
        id_packet.valid       = if_id_reg.valid;

        case (f.opcode)
            OP_IMM: begin
                if (f.funct3 == F3_ADD) begin // ADDI
                    id_packet.dest_reg = f.rd;
                    id_packet.alu_func = ALU_ADD;
                end
            end
            OP_REG: begin
                if (f.funct3 == F3_ADD && (f.funct7 == F7_ADD || f.funct7 == F7_SUB)) begin
                    id_packet.opb_select = OPB_IS_RS2;
                    id_packet.dest_reg   = f.rd;
                    id_packet.alu_func   = (f.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                end
            end
            OP_LOAD: begin
                if (f.funct3 == F3_WORD) begin // LW, address rs1 + imm
                    id_packet.dest_reg = f.rd;
                    id_packet.alu_func = ALU_ADD;
                    id_packet.rd_mem   = 1'b1;
                end
            end
            OP_STORE: begin
                if (f.funct3 == F3_WORD) begin // SW
                    id_packet.imm      = imm_s;
                    id_packet.alu_func = ALU_ADD;
                    id_packet.wr_mem   = 1'b1;
                end
            end
            OP_BRANCH: begin
                if (f.funct3 == F3_ADD) begin  // BEQ
                    id_packet.imm         = imm_b;
                    id_packet.cond_branch = 1'b1;
                end
            end
            OP_SYSTEM: id_packet.halt = (if_id_reg.inst == EBREAK);
            default: ;
        endcase
    end

endmodule

// File: stage_ex.sv
// Execute stage: operand B select, ALU and BEQ compare
`timescale 1ns/1ps
module stage_ex import mem_bus_pkg::*, cpu_types_pkg::*; (
    input  ID_EX_PACKET  id_ex_reg,
    output EX_MEM_PACKET ex_packet
);

    DATA  opb;
    DATA  alu_out;
    ADDR  target;
    logic taken;

    assign opb = (id_ex_reg.opb_select == OPB_IS_IMM) ? id_ex_reg.imm : id_ex_reg.rs2_value;

    always_comb begin
        case (id_ex_reg.alu_func)
            ALU_ADD: alu_out = id_ex_reg.rs1_value + opb; // Also load/store address
            ALU_SUB: alu_out = id_ex_reg.rs1_value - opb;
            default: alu_out = opb;
        endcase
    end

    // BEQ target and condition
    assign target = id_ex_reg.pc + id_ex_reg.imm;
    assign taken  = id_ex_reg.valid && id_ex_reg.cond_branch
                    && (id_ex_reg.rs1_value == id_ex_reg.rs2_value);

    always_comb begin
        // Not-taken branch carries NPC so the result is NPC either way
        if (id_ex_reg.cond_branch) begin
            ex_packet.alu_result = taken ? target : id_ex_reg.npc;
        end else begin
            ex_packet.alu_result = alu_out;
        end
        ex_packet.npc         = id_ex_reg.npc;
        ex_packet.rs2_value   = id_ex_reg.rs2_value;
        ex_packet.dest_reg    = id_ex_reg.dest_reg;
        ex_packet.rd_mem      = id_ex_reg.rd_mem;
        ex_packet.wr_mem      = id_ex_reg.wr_mem;
        ex_packet.take_branch = taken;
        ex_packet.halt        = id_ex_reg.halt;
        ex_packet.valid       = id_ex_reg.valid;
    end

endmodule

// File: stage_mem.sv
// Memory stage: load/store request generation and load result capture
`timescale 1ns/1ps
module stage_mem import mem_bus_pkg::*, cpu_types_pkg::*; (
    input  EX_MEM_PACKET     ex_mem_reg,
    dmem_if.mem_stage        dmem,
    output MEM_WB_PACKET     mem_packet
);

    logic mem_op;

    assign mem_op = ex_mem_reg.valid && (ex_mem_reg.rd_mem || ex_mem_reg.wr_mem);

    always_comb begin
        if (!mem_op) begin
            dmem.command = MEM_NONE;
        end else begin
            dmem.command = ex_mem_reg.rd_mem ? MEM_LOAD : MEM_STORE;
        end
        dmem.addr       = {ex_mem_reg.alu_result[31:2], 2'b00}; // Whole words only
        dmem.store_data = ex_mem_reg.rs2_value;

        if (ex_mem_reg.rd_mem) begin
            mem_packet.result = dmem.load_data;
        end else begin
            mem_packet.result = ex_mem_reg.take_branch ? ex_mem_reg.npc : ex_mem_reg.alu_result;
        end
        mem_packet.npc      = ex_mem_reg.npc;
        mem_packet.dest_reg = ex_mem_reg.dest_reg;
        mem_packet.halt     = ex_mem_reg.halt;
        mem_packet.valid    = ex_mem_reg.valid && (!mem_op || dmem.done); // Access finished
    end

endmodule

// File: mem_ctrl.sv
// Memory controller: port arbitration, outstanding load tag and load/store stall
`timescale 1ns/1ps
module mem_ctrl import mem_bus_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  MEM_COMMAND fetch_command,
    input  ADDR        fetch_addr,
    input  MEM_TAG     mem2proc_transaction_tag,
    input  DATA        mem2proc_data,
    input  MEM_TAG     mem2proc_data_tag,
    output MEM_TAG     fetch_tag,
    output MEM_COMMAND proc2mem_command,
    output ADDR        proc2mem_addr,
    output DATA        proc2mem_data,
    output logic       load_stall,
    dmem_if.ctrl       dmem
);

    MEM_TAG     load_tag;     // Outstanding load, NO_TAG when none
    logic       data_req;
    logic       load_sent;
    logic       accepted;
    MEM_COMMAND data_command; // Data command with repeat loads removed

    assign data_req     = dmem.command != MEM_NONE;
    assign load_sent    = load_tag != NO_TAG;
    assign accepted     = mem2proc_transaction_tag != NO_TAG;
    assign data_command = (dmem.command == MEM_LOAD && load_sent) ? MEM_NONE : dmem.command;

    ////////////////////
    // Port arbitration
    ////////////////////

    // Data side owns the port for the whole access
    always_comb begin
        if (data_req) begin
            proc2mem_command = data_command;
            proc2mem_addr    = dmem.addr;
        end else begin
            proc2mem_command = fetch_command;
            proc2mem_addr    = fetch_addr;
        end
    end

    assign proc2mem_data = dmem.store_data;
    assign fetch_tag     = (!data_req && fetch_command != MEM_NONE)
                           ? mem2proc_transaction_tag : NO_TAG;

    ////////////////////
    // Completion and stall
    ////////////////////

    assign dmem.load_data = mem2proc_data;
    assign dmem.done      = (data_command == MEM_STORE && accepted)
                            || (load_sent && mem2proc_data_tag == load_tag);
    assign load_stall     = data_req && !dmem.done; // Refusals stall too

    always_ff @(posedge clock) begin
        if (reset) begin
            load_tag <= NO_TAG;
        end else if (data_command == MEM_LOAD && accepted) begin
            load_tag <= mem2proc_transaction_tag;
        end else if (dmem.done) begin
            load_tag <= NO_TAG;             // Data back, free for next load
        end
    end

endmodule

// File: cpu.sv
// RTL top: five stages, stage registers, writeback select, valid token, commit and halt
`timescale 1ns/1ps
module cpu import mem_bus_pkg::*, cpu_types_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  MEM_TAG     mem2proc_transaction_tag,
    input  DATA        mem2proc_data,
    input  MEM_TAG     mem2proc_data_tag,
    output MEM_COMMAND proc2mem_command,
    output ADDR        proc2mem_addr,
    output DATA        proc2mem_data,
    output logic       commit_valid,
    output ADDR        commit_pc,
    output logic       commit_reg_en,
    output REG_IDX     commit_reg,
    output DATA        commit_data,
    output logic       halted
);

    IF_ID_PACKET  if_packet;
    IF_ID_PACKET  if_id_reg;
    ID_EX_PACKET  id_packet;
    ID_EX_PACKET  id_ex_reg;
    EX_MEM_PACKET ex_packet;
    EX_MEM_PACKET ex_mem_reg;
    MEM_WB_PACKET mem_packet;
    MEM_WB_PACKET mem_wb_reg;

    MEM_COMMAND fetch_command;
    ADDR        fetch_addr;
    MEM_TAG     fetch_tag;
    logic       load_stall;
    logic       start_valid_on_reset;
    logic       wb_valid;    // Token back from writeback
    logic       if_valid;
    logic       wb_en;

    dmem_if dmem ();

    ////////////////////
    // Valid token
    ////////////////////

    // One cycle pulse after reset drops
    always_ff @(posedge clock) begin
        start_valid_on_reset <= reset;
    end

    assign if_valid = start_valid_on_reset || wb_valid;

    ////////////////////
    // Stages and stage registers
    ////////////////////

    stage_if u_if (
        .clock(clock), .reset(reset), .if_valid(if_valid), .halt_seen(halted),
        .take_branch(ex_mem_reg.valid && ex_mem_reg.take_branch),
        .branch_target(ex_mem_reg.alu_result),
        .fetch_tag(fetch_tag), .mem_data_tag(mem2proc_data_tag), .mem_data(mem2proc_data),
        .fetch_command(fetch_command), .fetch_addr(fetch_addr), .if_packet(if_packet)
    );

    pipe_reg #(.PACKET(IF_ID_PACKET), .EMPTY(IF_ID_EMPTY)) u_if_id (
        .clock(clock), .reset(reset), .hold(load_stall), .flush(1'b0),
        .d(if_packet), .q(if_id_reg)
    );

    stage_id u_id (
        .clock(clock), .reset(reset), .if_id_reg(if_id_reg),
        .wb_en(wb_en), .wb_idx(mem_wb_reg.dest_reg), .wb_data(mem_wb_reg.result),
        .id_packet(id_packet)
    );

    pipe_reg #(.PACKET(ID_EX_PACKET), .EMPTY(ID_EX_EMPTY)) u_id_ex (
        .clock(clock), .reset(reset), .hold(load_stall), .flush(1'b0),
        .d(id_packet), .q(id_ex_reg)
    );

    stage_ex u_ex (.id_ex_reg(id_ex_reg), .ex_packet(ex_packet));

    pipe_reg #(.PACKET(EX_MEM_PACKET), .EMPTY(EX_MEM_EMPTY)) u_ex_mem (
        .clock(clock), .reset(reset), .hold(load_stall), .flush(1'b0),
        .d(ex_packet), .q(ex_mem_reg)
    );

    stage_mem u_mem (.ex_mem_reg(ex_mem_reg), .dmem(dmem.mem_stage), .mem_packet(mem_packet));

    mem_ctrl u_mem_ctrl (
        .clock(clock), .reset(reset),
        .fetch_command(fetch_command), .fetch_addr(fetch_addr),
        .mem2proc_transaction_tag(mem2proc_transaction_tag),
        .mem2proc_data(mem2proc_data), .mem2proc_data_tag(mem2proc_data_tag),
        .fetch_tag(fetch_tag), .proc2mem_command(proc2mem_command),
        .proc2mem_addr(proc2mem_addr), .proc2mem_data(proc2mem_data),
        .load_stall(load_stall), .dmem(dmem.ctrl)
    );

    // Bubble into MEM/WB while an access is still open
    pipe_reg #(.PACKET(MEM_WB_PACKET), .EMPTY(MEM_WB_EMPTY)) u_mem_wb (
        .clock(clock), .reset(reset), .hold(1'b0), .flush(load_stall),
        .d(mem_packet), .q(mem_wb_reg)
    );

    ////////////////////
    // Writeback and commit
    ////////////////////

    assign wb_en = mem_wb_reg.valid && (mem_wb_reg.dest_reg != ZERO_REG);

    always_ff @(posedge clock) begin
        if (reset) begin
            commit_valid  <= 1'b0;
            commit_reg_en <= 1'b0;
            wb_valid      <= 1'b0;
            halted        <= 1'b0;
        end else begin
            commit_valid  <= mem_wb_reg.valid;
            commit_reg_en <= wb_en;
            wb_valid      <= commit_valid;  // Token returns a cycle after commit
            if (mem_wb_reg.valid && mem_wb_reg.halt) begin
                halted <= 1'b1;             // Sticky, blocks further fetch
            end
        end
    end

    // Commit payload
    always_ff @(posedge clock) begin
        commit_pc   <= mem_wb_reg.npc - 32'd4;
        commit_reg  <= mem_wb_reg.dest_reg;
        commit_data <= mem_wb_reg.result;
    end

endmodule

// File: tb_cpu.sv
// Testbench: tagged memory model, program and commit tables, commit checks, halt check, timeout
`timescale 1ns/1ps
module tb_cpu import mem_bus_pkg::*; ();

    localparam int RESET_CYCLES   = 10;
    localparam int PROG_WORDS     = 18;
    localparam int COMMITS        = 17;
    localparam int TIMEOUT_CYCLES = COMMITS * 60 + 200;
    localparam int QUIET_CYCLES   = 20;   // Checked after EBREAK
    localparam int DATA_BASE      = 'h200 / 4;

    logic       clock;
    logic       reset;
    MEM_TAG     mem2proc_transaction_tag;
    DATA        mem2proc_data;
    MEM_TAG     mem2proc_data_tag;
    MEM_COMMAND proc2mem_command;
    ADDR        proc2mem_addr;
    DATA        proc2mem_data;
    logic       commit_valid;
    ADDR        commit_pc;
    logic       commit_reg_en;
    logic [4:0] commit_reg;
    DATA        commit_data;
    logic       halted;

    DATA         mem [MEM_WORDS];       // Memory model
    DATA         program_words [PROG_WORDS];
    ADDR         exp_pc [COMMITS];
    logic        exp_en [COMMITS];
    logic [4:0]  exp_reg [COMMITS];
    DATA         exp_data [COMMITS];
    int          fill_row;
    int          cycles;
    int          value_errors;
    int          other_errors;
    logic [31:0] rng;
    MEM_TAG      next_tag;
    logic        ret_valid;             // One load in flight
    int          ret_count;
    MEM_TAG      ret_tag;
    DATA         ret_data;
    int          word;

    cpu u_dut (.*);

    always #10 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
    end

    ////////////////////
    // Instruction encoders
    ////////////////////

    function automatic DATA addi_inst(input logic [4:0] rd, input logic [4:0] rs1, input int imm);
        return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic DATA add_inst(input logic [4:0] rd, input logic [4:0] rs1,
                                     input logic [4:0] rs2);
        return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic DATA sub_inst(input logic [4:0] rd, input logic [4:0] rs1,
                                     input logic [4:0] rs2);
        return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic DATA lw_inst(input logic [4:0] rd, input logic [4:0] rs1, input int imm);
        return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic DATA sw_inst(input logic [4:0] rs2, input logic [4:0] rs1, input int imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic DATA beq_inst(input logic [4:0] rs1, input logic [4:0] rs2, input int offset);
        return {offset[12], offset[10:5], rs2, rs1, 3'b000, offset[4:1], offset[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic expect_commit(input ADDR pc, input logic en, input logic [4:0] rd, input DATA d);
        exp_pc[fill_row]   = pc;
        exp_en[fill_row]   = en;
        exp_reg[fill_row]  = rd;
        exp_data[fill_row] = d;        // Ignored when nothing is written
        fill_row++;
    endtask

    ////////////////////
    // Program and expected commits
    ////////////////////

    task automatic build_tables();
        program_words[0]  = addi_inst(1, 0, 5);
        program_words[1]  = addi_inst(2, 0, -3);
        program_words[2]  = add_inst(3, 1, 2);
        program_words[3]  = sub_inst(4, 2, 1);
        program_words[4]  = addi_inst(0, 1, 7);     // Lost write to x0
        program_words[5]  = add_inst(6, 0, 1);      // x0 reads zero
        program_words[6]  = lw_inst(7, 0, 'h200);   // Preloaded words
        program_words[7]  = addi_inst(8, 7, 1);     // Wraps to min negative
        program_words[8]  = lw_inst(9, 0, 'h204);
        program_words[9]  = addi_inst(10, 9, 1);    // Wraps to zero
        program_words[10] = sw_inst(4, 0, 'h208);
        program_words[11] = lw_inst(11, 0, 'h208);  // Reads the store back
        program_words[12] = beq_inst(1, 6, 8);      // Taken
        program_words[13] = addi_inst(12, 0, 99);   // Skipped
        program_words[14] = beq_inst(1, 2, 8);      // Not taken
        program_words[15] = sub_inst(13, 0, 1);
        program_words[16] = sub_inst(14, 8, 1);
        program_words[17] = 32'h0010_0073;          // EBREAK

        fill_row = 0;
        expect_commit('h00, 1, 1, 32'd5);
        expect_commit('h04, 1, 2, 32'hFFFF_FFFD);
        expect_commit('h08, 1, 3, 32'd2);
        expect_commit('h0C, 1, 4, 32'hFFFF_FFF8);
        expect_commit('h10, 0, 0, 32'd0);
        expect_commit('h14, 1, 6, 32'd5);
        expect_commit('h18, 1, 7, 32'h7FFF_FFFF);
        expect_commit('h1C, 1, 8, 32'h8000_0000);
        expect_commit('h20, 1, 9, 32'hFFFF_FFFF);
        expect_commit('h24, 1, 10, 32'd0);
        expect_commit('h28, 0, 0, 32'd0);
        expect_commit('h2C, 1, 11, 32'hFFFF_FFF8);
        expect_commit('h30, 0, 0, 32'd0);
        expect_commit('h38, 0, 0, 32'd0);
        expect_commit('h3C, 1, 13, 32'hFFFF_FFFB);
        expect_commit('h40, 1, 14, 32'h7FFF_FFFB);
        expect_commit('h44, 0, 0, 32'd0);

        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'h6B00_0000 ^ (i * 4);       // Unique per address
        end
        for (int i = 0; i < PROG_WORDS; i++) begin
            mem[i] = program_words[i];
        end
        mem[DATA_BASE]     = 32'h7FFF_FFFF;
        mem[DATA_BASE + 1] = 32'hFFFF_FFFF;
        mem[DATA_BASE + 2] = 32'h1234_5678;         // Overwritten by SW
    endtask

    ////////////////////
    // Memory model
    ////////////////////

    always @(posedge clock) begin
        #1;
        mem2proc_data_tag = NO_TAG;
        mem2proc_data     = '0;
        if (ret_valid) begin
            ret_count = ret_count - 1;
            if (ret_count == 0) begin
                mem2proc_data_tag = ret_tag;       // Data back with its tag
                mem2proc_data     = ret_data;
                ret_valid         = 1'b0;
            end
        end
        mem2proc_transaction_tag = NO_TAG;          // Refused unless accepted below
        if (proc2mem_command != MEM_NONE) begin
            rng = lcg_next(rng);
            if (rng[31:30] != 2'b00) begin
                word = int'(proc2mem_addr[31:2]);
                if (proc2mem_addr[1:0] != 2'b00 || proc2mem_addr[31:2] >= MEM_WORDS) begin
                    $display("memory access to address %h is out of range", proc2mem_addr);
                    other_errors++;
                end else begin
                    mem2proc_transaction_tag = next_tag;
                    if (proc2mem_command == MEM_STORE) begin
                        mem[word] = proc2mem_data;
                    end else begin
                        if (ret_valid) begin
                            $display("a second load was accepted while one was in flight");
                            other_errors++;
                        end
                        ret_valid = 1'b1;
                        ret_tag   = next_tag;
                        ret_data  = mem[word];
                        ret_count = int'(rng[29:28]) + 1;   // 1 to 4 cycles
                    end
                    next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                end
            end
        end
    end

    ////////////////////
    // Checks and end of run
    ////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        value_errors++;
        $display("error at %0.1f ns: %s expected %h, actual %h",
                 $realtime, name, expected, actual);
    endtask

    // Idle port and no commit, halted as given
    task automatic check_quiet(input logic exp_halted);
        if (commit_valid !== 1'b0) begin
            report_mismatch("commit_valid", 0, commit_valid);
        end
        if (halted !== exp_halted) begin
            report_mismatch("halted", exp_halted, halted);
        end
        if (proc2mem_command !== MEM_NONE) begin
            report_mismatch("proc2mem_command", MEM_NONE, proc2mem_command);
        end
    endtask

    task automatic check_commit(input int row);
        if (commit_pc !== exp_pc[row]) begin
            report_mismatch("commit_pc", exp_pc[row], commit_pc);
        end
        if (commit_reg_en !== exp_en[row]) begin
            report_mismatch("commit_reg_en", exp_en[row], commit_reg_en);
        end
        if (exp_en[row] && commit_reg !== exp_reg[row]) begin
            report_mismatch("commit_reg", exp_reg[row], commit_reg);
        end
        if (exp_en[row] && commit_data !== exp_data[row]) begin
            report_mismatch("commit_data", exp_data[row], commit_data);
        end
        if (halted !== (row == COMMITS - 1)) begin   // Rises with the EBREAK commit
            report_mismatch("halted", row == COMMITS - 1, halted);
        end
    endtask

    task automatic finish_run();
        $display("Check summary: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    initial begin : watchdog
        wait (cycles >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, the program did not halt", TIMEOUT_CYCLES);
        other_errors++;
        finish_run();
    end

    initial begin
        clock                    = 1'b0;
        reset                    = 1'b1;
        mem2proc_transaction_tag = NO_TAG;
        mem2proc_data            = '0;
        mem2proc_data_tag        = NO_TAG;
        cycles       = 0;
        value_errors = 0;
        other_errors = 0;
        rng          = 32'h1145ea61;
        next_tag     = 4'd1;
        ret_valid    = 1'b0;
        build_tables();

        repeat (RESET_CYCLES) begin
            @(negedge clock);
            check_quiet(1'b0);
        end
        @(posedge clock);
        #1 reset = 1'b0;
        @(negedge clock);
        check_quiet(1'b0);                  // Cycle after reset, still no fetch

        // Sample mid-cycle, one table row per commit
        for (int row = 0; row < COMMITS; row++) begin
            do begin
                @(negedge clock);
            end while (commit_valid !== 1'b1);
            check_commit(row);
        end

        repeat (QUIET_CYCLES) begin
            @(negedge clock);
            check_quiet(1'b1);
        end
        finish_run();
    end

endmodule

// File: cpu.f
mem_bus_pkg.sv
cpu_types_pkg.sv
dmem_if.sv
pipe_reg.sv
stage_if.sv
stage_id.sv
stage_ex.sv
stage_mem.sv
mem_ctrl.sv
cpu.sv
tb_cpu.sv
